// ==== hdl/bldc_pkg.sv ====
`default_nettype none

package bldc_pkg;

    // ==================================================
    // PWM and duty cycle
    // ==================================================

    // Duty cycle width and its full scale value
    localparam int DUTY_W = 8;
    localparam int MAX_DUTY = 255;

    // One PWM period is a full pass of the per-phase counter
    localparam int PWM_PERIOD = 256;
    localparam int PWM_CNT_W = $clog2(PWM_PERIOD);

    // Clocks with both switches of a half-bridge off around every edge
    localparam int DEAD_TIME = 4;
    localparam int GAP_W = $clog2(DEAD_TIME + 1);

    // Role of one half-bridge within the current commutation step
    localparam logic [1:0] ROLE_FLOAT = 2'd0;
    localparam logic [1:0] ROLE_DRIVEN = 2'd1;
    localparam logic [1:0] ROLE_SUNK = 2'd2;

    // ==================================================
    // Startup ramp
    // ==================================================

    // Lowest duty that can turn the motor, about 2% of full scale
    localparam int MIN_DUTY = 5;

    // The ramp takes STARTUP_STEPS steps of STARTUP_STEP_CLOCKS clocks each
    localparam int STARTUP_STEP_CLOCKS = 16;
    localparam int STARTUP_STEPS = 15;
    localparam int STEP_CLK_W = $clog2(STARTUP_STEP_CLOCKS);
    localparam int STEP_CNT_W = $clog2(STARTUP_STEPS + 1);

    // ==================================================
    // Hall sensor monitor
    // ==================================================

    // The sensor is sampled once every HALL_SAMPLE_CLOCKS clocks
    localparam int HALL_SAMPLE_CLOCKS = 4;
    localparam int HALL_DIV_W = $clog2(HALL_SAMPLE_CLOCKS);

    // Consecutive equal samples needed before a latch changes
    localparam int HALL_STEADY_COUNT = 7;
    localparam int HALL_CNT_W = $clog2(HALL_STEADY_COUNT + 1);

    typedef enum logic [2:0] {
        STATE_STOP      = 3'd0,
        STATE_STARTUP   = 3'd1,
        STATE_RUN       = 3'd2,
        STATE_POLL_HALL = 3'd3,
        STATE_ERR       = 3'd4
    } motor_state_e;

    // Synchronised hall code plus the monitor latches
    typedef struct packed {
        logic [2:0] hall_s;
        logic       fault_req;
        logic       hw_fault;
        logic       disconnected;
    } hall_status_t;

    // What the sequencer asks of the bridge
    typedef struct packed {
        logic              active;
        logic              direction;
        logic [DUTY_W-1:0] duty;
    } drive_cmd_t;

    // Gate drives with bit 0 for phase A, bit 1 for B and bit 2 for C
    typedef struct packed {
        logic [2:0] high;
        logic [2:0] low;
    } phase_drive_t;

endpackage

`default_nettype wire

// ==== hdl/hall_monitor.sv ====
`default_nettype none
`timescale 1ns/1ps

module hall_monitor
    import bldc_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic [2:0]   hall,
    input  logic         polling,
    output hall_status_t status
);

    logic [2:0]            hall_q;
    logic [HALL_DIV_W-1:0] sample_div;
    logic                  sample;
    logic                  is_zero;
    logic                  is_ones;
    logic                  is_valid;
    logic [HALL_CNT_W-1:0] zero_cnt;
    logic [HALL_CNT_W-1:0] ones_cnt;
    logic [HALL_CNT_W-1:0] valid_cnt;
    logic                  zero_hit;
    logic                  ones_hit;
    logic                  valid_hit;
    logic                  fault_req;
    logic                  hw_fault;
    logic                  disconnected;

    // One register brings the asynchronous sensor lines into the clk domain
    always_ff @(posedge clk) begin
        hall_q <= hall;
    end

    // Free-running divider that takes a sample on its last count
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_div <= '0;
        end else if (sample) begin
            sample_div <= '0;
        end else begin
            sample_div <= sample_div + 1'b1;
        end
    end

    assign sample = sample_div == HALL_DIV_W'(HALL_SAMPLE_CLOCKS - 1);

    // 000 means a shorted line, since all three inputs have pull-ups
    assign is_zero = hall_q == 3'b000;
    // 111 is what the pull-ups give with no sensor plugged in
    assign is_ones = hall_q == 3'b111;
    assign is_valid = !is_zero && !is_ones;

    // A hit is the sample that completes a run of HALL_STEADY_COUNT
    assign zero_hit = sample && is_zero && (zero_cnt == HALL_CNT_W'(HALL_STEADY_COUNT - 1));
    assign ones_hit = sample && is_ones && (ones_cnt == HALL_CNT_W'(HALL_STEADY_COUNT - 1));
    assign valid_hit = sample && is_valid && polling &&
                       (valid_cnt == HALL_CNT_W'(HALL_STEADY_COUNT - 1));

    // Run counters restart on any other code and after each hit
    always_ff @(posedge clk) begin
        if (rst) begin
            zero_cnt <= '0;
            ones_cnt <= '0;
            valid_cnt <= '0;
        end else if (sample) begin
            zero_cnt <= (is_zero && !zero_hit) ? zero_cnt + 1'b1 : '0;
            ones_cnt <= (is_ones && !ones_hit) ? ones_cnt + 1'b1 : '0;
            // Reconnection is only looked for while the sequencer polls
            valid_cnt <= (is_valid && polling && !valid_hit) ? valid_cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fault_req <= 1'b0;
            hw_fault <= 1'b0;
            disconnected <= 1'b0;
        end else begin
            // Pulse only on a fresh set because a held code keeps hitting
            fault_req <= (zero_hit && !hw_fault) || (ones_hit && !disconnected);
            if (zero_hit) begin
                hw_fault <= 1'b1;
            end
            // Unplugging the sensor also clears a wiring fault
            if (ones_hit) begin
                disconnected <= 1'b1;
                hw_fault <= 1'b0;
            end
            if (valid_hit) begin
                disconnected <= 1'b0;
            end
        end
    end

    assign status = '{
        hall_s:       hall_q,
        fault_req:    fault_req,
        hw_fault:     hw_fault,
        disconnected: disconnected
    };

endmodule

`default_nettype wire

// ==== hdl/motor_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module motor_sequencer
    import bldc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic [DUTY_W-1:0] duty,
    input  logic              direction,
    input  hall_status_t      status,
    output logic              polling,
    output drive_cmd_t        cmd,
    output logic              fault
);

    motor_state_e          state;
    logic [STEP_CLK_W-1:0] step_clk;
    logic [STEP_CNT_W-1:0] step_cnt;
    logic [DUTY_W-1:0]     duty_r;
    logic                  duty_ok;
    logic                  step_tick;
    logic                  last_step;

    // Anything at or below MIN_DUTY is taken as a stop request
    assign duty_ok = duty > DUTY_W'(MIN_DUTY);

    // End of one ramp step
    assign step_tick = step_clk == STEP_CLK_W'(STARTUP_STEP_CLOCKS - 1);
    // The final step hands over to RUN instead of adding one more
    assign last_step = step_cnt == STEP_CNT_W'(STARTUP_STEPS - 1);

    // ==================================================
    // Motor state machine
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STATE_STOP;
            step_clk <= '0;
            step_cnt <= '0;
            duty_r <= '0;
        end else if (!en) begin
            // Disabling the driver also drops a pending error
            state <= STATE_STOP;
            step_clk <= '0;
            step_cnt <= '0;
            duty_r <= '0;
        end else if (status.fault_req) begin
            // A lost sensor is waited out, anything else is an error
            state <= status.disconnected ? STATE_POLL_HALL : STATE_ERR;
            step_clk <= '0;
            step_cnt <= '0;
            duty_r <= '0;
        end else begin
            case (state)
                STATE_STOP: begin
                    step_clk <= '0;
                    step_cnt <= '0;
                    // Latches that were set while disabled still block a start
                    if (status.hw_fault) begin
                        state <= STATE_ERR;
                    end else if (status.disconnected) begin
                        state <= STATE_POLL_HALL;
                    end else if (duty_ok) begin
                        // Ramp begins at the lowest usable duty
                        state <= STATE_STARTUP;
                        duty_r <= DUTY_W'(MIN_DUTY);
                    end else begin
                        duty_r <= '0;
                    end
                end

                STATE_STARTUP: begin
                    if (!duty_ok) begin
                        state <= STATE_STOP;
                        duty_r <= '0;
                    end else if (step_tick) begin
                        step_clk <= '0;
                        if (last_step) begin
                            state <= STATE_RUN;
                            duty_r <= duty;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                            duty_r <= duty_r + 1'b1;
                        end
                    end else begin
                        step_clk <= step_clk + 1'b1;
                    end
                end

                STATE_RUN: begin
                    // Duty tracks the input with one register of delay
                    if (!duty_ok) begin
                        state <= STATE_STOP;
                        duty_r <= '0;
                    end else begin
                        duty_r <= duty;
                    end
                end

                STATE_POLL_HALL: begin
                    // The monitor clears the latch once a legal code is steady
                    if (!status.disconnected) begin
                        state <= STATE_STOP;
                    end
                end

                STATE_ERR: begin
                    // Left only when the sensor is unplugged, which clears hw_fault
                    if (!status.hw_fault) begin
                        state <= STATE_POLL_HALL;
                    end
                end

                default: begin
                    state <= STATE_STOP;
                end
            endcase
        end
    end

    // The hall monitor looks for reconnection only in this state
    assign polling = state == STATE_POLL_HALL;

    // Fault drops at once with en
    assign fault = en && (state == STATE_ERR);

    assign cmd = '{
        active:    (state == STATE_STARTUP) || (state == STATE_RUN),
        direction: direction,
        duty:      duty_r
    };

endmodule

`default_nettype wire

// ==== hdl/phase_pwm.sv ====
`default_nettype none
`timescale 1ns/1ps

module phase_pwm
    import bldc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [DUTY_W-1:0] duty,
    input  logic [1:0]        role,
    output logic              high,
    output logic              low
);

    logic [PWM_CNT_W-1:0] cnt;
    logic [DUTY_W:0]      low_start;
    logic                 high_want;
    logic                 low_want;
    logic [GAP_W-1:0]     high_gap;
    logic [GAP_W-1:0]     low_gap;
    logic                 high_ok;
    logic                 low_ok;

    // The period counters of all three phases leave reset together and stay aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == PWM_CNT_W'(PWM_PERIOD - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One bit wider so a duty near full scale cannot wrap
    assign low_start = {1'b0, duty} + (DUTY_W + 1)'(DEAD_TIME);

    // ==================================================
    // PWM rule per role
    // ==================================================

    always_comb begin
        high_want = 1'b0;
        low_want = 1'b0;
        case (role)
            ROLE_DRIVEN: begin
                // High for the duty part, low for the rest, dead time between
                high_want = (cnt >= PWM_CNT_W'(DEAD_TIME)) && (cnt < duty);
                // The counter never passes MAX_DUTY, so low runs to the end of the period
                low_want = {1'b0, cnt} >= low_start;
            end
            ROLE_SUNK: begin
                // The low switch carries the return current and skips the first counts
                low_want = cnt >= PWM_CNT_W'(DEAD_TIME);
            end
            default: begin
                high_want = 1'b0;
                low_want = 1'b0;
            end
        endcase
    end

    // Gap counters give dead time on role changes too, such as a direction flip
    assign high_ok = !low && (low_gap == GAP_W'(DEAD_TIME - 1));
    assign low_ok = !high && (high_gap == GAP_W'(DEAD_TIME - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            high <= 1'b0;
            low <= 1'b0;
            high_gap <= GAP_W'(DEAD_TIME - 1);
            low_gap <= GAP_W'(DEAD_TIME - 1);
        end else begin
            high <= high_want && high_ok;
            low <= low_want && low_ok;
            // Count clocks since each switch was last on, saturating
            if (high) begin
                high_gap <= '0;
            end else if (high_gap != GAP_W'(DEAD_TIME - 1)) begin
                high_gap <= high_gap + 1'b1;
            end
            if (low) begin
                low_gap <= '0;
            end else if (low_gap != GAP_W'(DEAD_TIME - 1)) begin
                low_gap <= low_gap + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/commutation_bridge.sv ====
`default_nettype none
`timescale 1ns/1ps

module commutation_bridge
    import bldc_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  drive_cmd_t   cmd,
    input  logic [2:0]   hall_s,
    output phase_drive_t phase
);

    logic [2:0] fwd_drv;
    logic [2:0] fwd_snk;
    logic [2:0] drv;
    logic [2:0] snk;
    logic [2:0] high_w;
    logic [2:0] low_w;

    // Forward six-step table with a one-hot driven and sunk phase per hall code
    always_comb begin
        case (hall_s)
            3'b001: {fwd_drv, fwd_snk} = {3'b001, 3'b010};
            3'b011: {fwd_drv, fwd_snk} = {3'b001, 3'b100};
            3'b010: {fwd_drv, fwd_snk} = {3'b010, 3'b100};
            3'b110: {fwd_drv, fwd_snk} = {3'b010, 3'b001};
            3'b100: {fwd_drv, fwd_snk} = {3'b100, 3'b001};
            3'b101: {fwd_drv, fwd_snk} = {3'b100, 3'b010};
            // Illegal codes leave every phase floating
            default: {fwd_drv, fwd_snk} = {3'b000, 3'b000};
        endcase
    end

    // Reverse (direction 1) swaps the driven and sunk phase of each step
    assign drv = cmd.direction ? fwd_snk : fwd_drv;
    assign snk = cmd.direction ? fwd_drv : fwd_snk;

    for (genvar i = 0; i < 3; i++) begin : g_phase
        logic [1:0] role;

        assign role = !cmd.active ? ROLE_FLOAT :
                      drv[i]      ? ROLE_DRIVEN :
                      snk[i]      ? ROLE_SUNK : ROLE_FLOAT;

        phase_pwm u_pwm (
            .clk  (clk),
            .rst  (rst),
            .duty (cmd.duty),
            .role (role),
            .high (high_w[i]),
            .low  (low_w[i])
        );
    end

    // Output register in front of the gate drivers
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= '{high: high_w, low: low_w};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bldc_driver.sv ====
`default_nettype none
`timescale 1ns/1ps

module bldc_driver
    import bldc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic [2:0]        hall,
    input  logic [DUTY_W-1:0] duty,
    input  logic              direction,
    output phase_drive_t      phase,
    output logic              connected,
    output logic              fault
);

    hall_status_t status;
    drive_cmd_t   cmd;
    logic         polling;

    // Sensor synchroniser and fault latches
    hall_monitor u_hall_monitor (
        .clk     (clk),
        .rst     (rst),
        .hall    (hall),
        .polling (polling),
        .status  (status)
    );

    // State machine and startup ramp
    motor_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .duty      (duty),
        .direction (direction),
        .status    (status),
        .polling   (polling),
        .cmd       (cmd),
        .fault     (fault)
    );

    // Six-step decode and the three half-bridges
    commutation_bridge u_bridge (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .hall_s (status.hall_s),
        .phase  (phase)
    );

    assign connected = !status.disconnected;

endmodule

`default_nettype wire

// ==== test/bldc_driver_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module bldc_driver_asserts
    import bldc_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              en,
    input logic [2:0]        hall,
    input logic [DUTY_W-1:0] duty,
    input logic              direction,
    input phase_drive_t      phase,
    input logic              connected,
    input logic              fault
);

    // Longest time from a steady hall code to a changed latch
    localparam int LATCH_BOUND = HALL_SAMPLE_CLOCKS * (HALL_STEADY_COUNT + 1) + 2;

    int unsigned fail_count = 0;
    logic [1:0]  settle;
    logic        settled;
    logic        stopping;
    logic        legal_hall;

    // Enough history after reset for the hall and direction look-back
    always_ff @(posedge clk) begin
        if (rst) begin
            settle <= '0;
        end else if (settle != 2'd3) begin
            settle <= settle + 1'b1;
        end
    end

    assign settled = settle == 2'd3;
    assign stopping = !en || (duty <= DUTY_W'(MIN_DUTY));
    assign legal_hall = (hall != 3'b000) && (hall != 3'b111);

    // Floating phase of each step is the same in both directions
    function automatic logic [2:0] floating_mask(input logic [2:0] code);
        case (code)
            3'b001, 3'b110: floating_mask = 3'b100;
            3'b011, 3'b100: floating_mask = 3'b010;
            3'b010, 3'b101: floating_mask = 3'b001;
            default: floating_mask = 3'b111;
        endcase
    endfunction

    // Reverse sinks the phase that forward drives
    function automatic logic [2:0] sunk_mask(input logic [2:0] code, input logic rev);
        case (code)
            3'b001: sunk_mask = rev ? 3'b001 : 3'b010;
            3'b011: sunk_mask = rev ? 3'b001 : 3'b100;
            3'b010: sunk_mask = rev ? 3'b010 : 3'b100;
            3'b110: sunk_mask = rev ? 3'b010 : 3'b001;
            3'b100: sunk_mask = rev ? 3'b100 : 3'b001;
            3'b101: sunk_mask = rev ? 3'b100 : 3'b010;
            default: sunk_mask = 3'b000;
        endcase
    endfunction

    // ==================================================
    // Reset and bridge safety
    // ==================================================

    a_reset_values: assert property (@(posedge clk)
        rst |=> (phase == '0) && !fault && connected)
        else begin
            $error("MISMATCH reset phase 0x%h fault 0x%h connected 0x%h, expected 0x0 0x0 0x1",
                   $sampled(phase), $sampled(fault), $sampled(connected));
            fail_count = fail_count + 1;
        end

    // Both switches of one half-bridge on would short the supply
    a_no_shoot_through: assert property (@(posedge clk) disable iff (rst)
        (phase.high & phase.low) == 3'b000)
        else begin
            $error("MISMATCH phase.high 0x%h phase.low 0x%h overlap",
                   $sampled(phase.high), $sampled(phase.low));
            fail_count = fail_count + 1;
        end

    // Hall reaches the outputs 3 clocks later, direction 2 clocks later
    a_commutation_roles: assert property (@(posedge clk) disable iff (rst)
        settled |->
            (((phase.high | phase.low) & floating_mask($past(hall, 3))) == 3'b000) &&
            ((phase.high & sunk_mask($past(hall, 3), $past(direction, 2))) == 3'b000))
        else begin
            $error("MISMATCH phase 0x%h for hall 0x%h direction 0x%h",
                   $sampled(phase), $past(hall, 3), $past(direction, 2));
            fail_count = fail_count + 1;
        end

    for (genvar i = 0; i < 3; i++) begin : g_dead_time
        a_low_after_high: assert property (@(posedge clk) disable iff (rst)
            $fell(phase.high[i]) |-> !phase.low[i] [*DEAD_TIME])
            else begin
                $error("MISMATCH phase.low[%0d] 0x%h inside dead time", i, $sampled(phase.low[i]));
                fail_count = fail_count + 1;
            end

        a_high_after_low: assert property (@(posedge clk) disable iff (rst)
            $fell(phase.low[i]) |-> !phase.high[i] [*DEAD_TIME])
            else begin
                $error("MISMATCH phase.high[%0d] 0x%h inside dead time", i, $sampled(phase.high[i]));
                fail_count = fail_count + 1;
            end
    end

    // ==================================================
    // Stop and fault handling
    // ==================================================

    a_stop_clears_phase: assert property (@(posedge clk) disable iff (rst)
        stopping [*3] |=> phase == '0)
        else begin
            $error("MISMATCH phase 0x%h expected 0x0 after stop", $sampled(phase));
            fail_count = fail_count + 1;
        end

    a_fault_clears_phase: assert property (@(posedge clk) disable iff (rst)
        fault [*3] |-> phase == '0)
        else begin
            $error("MISMATCH phase 0x%h expected 0x0 while fault is set", $sampled(phase));
            fail_count = fail_count + 1;
        end

    a_wiring_fault: assert property (@(posedge clk) disable iff (rst)
        (en && connected && hall == 3'b000) [*LATCH_BOUND] |-> fault)
        else begin
            $error("MISMATCH fault 0x%h expected 0x1 with hall held at 0x0", $sampled(fault));
            fail_count = fail_count + 1;
        end

    a_disconnect: assert property (@(posedge clk) disable iff (rst)
        (en && hall == 3'b111) [*LATCH_BOUND] |-> !fault && !connected)
        else begin
            $error("MISMATCH fault 0x%h connected 0x%h expected 0x0 0x0 with hall at 0x7",
                   $sampled(fault), $sampled(connected));
            fail_count = fail_count + 1;
        end

    a_reconnect: assert property (@(posedge clk) disable iff (rst)
        (en && legal_hall) [*LATCH_BOUND] |-> connected)
        else begin
            $error("MISMATCH connected 0x%h expected 0x1 with a legal hall code",
                   $sampled(connected));
            fail_count = fail_count + 1;
        end

endmodule

bind bldc_driver bldc_driver_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .hall      (hall),
    .duty      (duty),
    .direction (direction),
    .phase     (phase),
    .connected (connected),
    .fault     (fault)
);

`default_nettype wire

// ==== test/bldc_driver_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module bldc_driver_tb
    import bldc_pkg::*;
();

    // ==================================================
    // Run length
    // ==================================================

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 2;
    localparam int RNG_SEED = 9;
    // Each code is held longer than the startup ramp and one PWM period
    localparam int HOLD_CYCLES = 300;
    localparam int SHORT_HOLD = 20;
    localparam int RUN_DUTY = 200;
    // The monitor needs at most this long to change a latch
    localparam int LATCH_BOUND = HALL_SAMPLE_CLOCKS * (HALL_STEADY_COUNT + 1) + 2;
    localparam int WAIT_LIMIT = LATCH_BOUND + 8;
    localparam int COMMUTATION_CYCLES = 2 * 6 * HOLD_CYCLES;
    localparam int STOP_CYCLES = HOLD_CYCLES + 3 * SHORT_HOLD;
    localparam int FAULT_CYCLES = 3 * WAIT_LIMIT + 4 * SHORT_HOLD;
    localparam int TEST_CYCLES = RESET_CYCLES + COMMUTATION_CYCLES + STOP_CYCLES + FAULT_CYCLES;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1800;

    logic              clk;
    logic              rst;
    logic              en;
    logic [2:0]        hall;
    logic [DUTY_W-1:0] duty;
    logic              direction;
    phase_drive_t      phase;
    logic              connected;
    logic              fault;

    bldc_driver UUT (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .hall      (hall),
        .duty      (duty),
        .direction (direction),
        .phase     (phase),
        .connected (connected),
        .fault     (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // The run ends here if the stimulus ever stalls
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the stimulus finished", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog timeout");
    end

    // Stops the run half a clock after the first failed assertion
    always @(negedge clk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("A bound assertion on the DUT ports failed");
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopping at the first failed check");
        end
    end

    // Forward six-step order of the hall sensor
    function automatic logic [2:0] forward_code(input int step);
        case (step)
            0: forward_code = 3'b001;
            1: forward_code = 3'b011;
            2: forward_code = 3'b010;
            3: forward_code = 3'b110;
            4: forward_code = 3'b100;
            default: forward_code = 3'b101;
        endcase
    endfunction

    // Steps the sensor through one electrical turn
    task automatic step_through_codes(input logic rev);
        direction = rev;
        for (int step = 0; step < 6; step++) begin
            hall = forward_code(step);
            repeat (HOLD_CYCLES) @(negedge clk);
        end
    endtask

    task automatic wait_for_fault(input logic want);
        int waited;
        waited = 0;
        while (fault !== want && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (fault !== want) begin
            $display("Timed out after %0d cycles waiting for fault to become %0b", waited, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "Fault wait timeout");
        end
    endtask

    task automatic wait_for_connected(input logic want);
        int waited;
        waited = 0;
        while (connected !== want && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (connected !== want) begin
            $display("Timed out after %0d cycles waiting for connected to become %0b",
                     waited, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "Connected wait timeout");
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        rst = 1'b1;
        en = 1'b0;
        hall = 3'b001;
        duty = '0;
        direction = 1'b0;
        void'($urandom(RNG_SEED));

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // First code also carries the startup ramp into RUN
        en = 1'b1;
        duty = DUTY_W'(RUN_DUTY);
        step_through_codes(1'b0);
        step_through_codes(1'b1);

        // A duty at or below the minimum is a stop request
        duty = DUTY_W'($urandom % (MIN_DUTY + 1));
        repeat (SHORT_HOLD) @(negedge clk);
        duty = DUTY_W'(RUN_DUTY);
        repeat (HOLD_CYCLES) @(negedge clk);
        en = 1'b0;
        repeat (SHORT_HOLD) @(negedge clk);
        en = 1'b1;
        repeat (SHORT_HOLD) @(negedge clk);

        // Shorted sensor, then unplugged sensor, then plugged back in
        hall = 3'b000;
        wait_for_fault(1'b1);
        repeat (SHORT_HOLD) @(negedge clk);
        // A legal code keeps the wiring fault, so the bridge must stay off on its own
        hall = 3'b110;
        repeat (SHORT_HOLD) @(negedge clk);
        hall = 3'b111;
        wait_for_fault(1'b0);
        wait_for_connected(1'b0);
        repeat (SHORT_HOLD) @(negedge clk);
        hall = 3'b011;
        wait_for_connected(1'b1);
        repeat (SHORT_HOLD) @(negedge clk);

        if (UUT.u_asserts.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "Checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/bldc_pkg.sv
hdl/hall_monitor.sv
hdl/motor_sequencer.sv
hdl/phase_pwm.sv
hdl/commutation_bridge.sv
hdl/bldc_driver.sv
test/bldc_driver_asserts.sv
test/bldc_driver_tb.sv
